//--- Makefile
SRCS = regmap_pkg.sv regmap_entry.sv regmap.sv regmap_csr.sv regmap_top.sv tb_regmap.sv

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_regmap: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_regmap -f tb.f

# The log decides the result, so a run without the pass line fails
run: obj_dir/Vtb_regmap
	./obj_dir/Vtb_regmap > sim.log 2>&1; cat sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- regmap.sv
// ============================================================
// Rename table array
// Decodes the rename and retire ports into per-entry enables,
// merges hardware and software flush, hard-wires register
// zero and muxes two source lookups and one debug port
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module regmap (
    input  logic                     clk,
    input  logic                     i_rst,

    // Branch or exception flush and the flush command from the CSR block
    input  logic                     i_flush,
    input  logic                     i_sw_flush,

    input  regmap_pkg::rename_req_t  i_rename,
    input  regmap_pkg::retire_req_t  i_retire,

    // Source operand lookups for dispatch
    input  regmap_pkg::regmap_addr_t i_src0_addr,
    input  regmap_pkg::regmap_addr_t i_src1_addr,
    output regmap_pkg::lookup_rsp_t  o_src0,
    output regmap_pkg::lookup_rsp_t  o_src1,

    // Debug readback port used by the CSR block
    input  regmap_pkg::regmap_addr_t i_dbg_addr,
    output regmap_pkg::lookup_rsp_t  o_dbg
);
    import regmap_pkg::*;

    logic                 flush;
    logic [REG_COUNT-1:1] rename_en;
    logic [REG_COUNT-1:1] retire_en;
    lookup_rsp_t          entries [REG_COUNT];

    // Both flush sources have the same effect on every entry
    assign flush = i_flush | i_sw_flush;

    // One-hot decode of the destination register for each port
    // Register zero has no entry, so requests to it decode to nothing
    always_comb begin
        for (int r = 1; r < REG_COUNT; r++) begin
            rename_en[r] = i_rename.en && (i_rename.rd == regmap_addr_t'(r));
            retire_en[r] = i_retire.en && (i_retire.rd == regmap_addr_t'(r));
        end
    end

    // Register zero always reads as a ready zero with no producer
    assign entries[0].data = '0;
    assign entries[0].tag  = '0;
    assign entries[0].rdy  = 1'b1;

    for (genvar r = 1; r < REG_COUNT; r++) begin : g_entry
        regmap_entry i_regmap_entry (
            .clk           (clk),
            .i_rst         (i_rst),
            .i_flush       (flush),
            .i_rename_en   (rename_en[r]),
            .i_rename_tag  (i_rename.tag),
            .i_retire_en   (retire_en[r]),
            .i_retire_data (i_retire.data),
            .i_retire_tag  (i_retire.tag),
            .o_entry       (entries[r])
        );
    end

    // Lookups read registered state only, so a retire in this cycle is
    // not visible until the next one
    assign o_src0 = entries[i_src0_addr];
    assign o_src1 = entries[i_src1_addr];
    assign o_dbg  = entries[i_dbg_addr];

    // Renames and retires aimed at register zero must never disturb it
    a_src0_zero: assert property (@(posedge clk) disable iff (i_rst)
        (i_src0_addr == '0) |-> (o_src0.rdy && (o_src0.data == '0)));
    a_src1_zero: assert property (@(posedge clk) disable iff (i_rst)
        (i_src1_addr == '0) |-> (o_src1.rdy && (o_src1.data == '0)));

endmodule

`default_nettype wire

//--- regmap_csr.sv
// ============================================================
// Wishbone classic configuration and debug slave
// Single-cycle ack, software flush command, rename and
// retire event counters, data and status readback windows
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module regmap_csr (
    input  logic                     clk,
    input  logic                     i_rst,

    input  regmap_pkg::wb_req_t      i_wb,
    output regmap_pkg::wb_rsp_t      o_wb,

    // Qualified rename and retire strobes, already filtered for register zero
    input  logic                     i_rename_evt,
    input  logic                     i_retire_evt,

    // One-cycle flush pulse aligned with the ack of the CTRL write
    output logic                     o_sw_flush,

    // Debug lookup into the array
    output regmap_pkg::regmap_addr_t o_dbg_addr,
    input  regmap_pkg::lookup_rsp_t  i_dbg
);
    import regmap_pkg::*;

    // Each readback window spans REG_COUNT words above its base
    localparam int WIN_LSB = REG_ADDR_WIDTH + 2;

    logic                     req;
    logic                     wr_req;
    logic                     word_aligned;
    logic                     hit_ctrl;
    logic                     hit_rename;
    logic                     hit_retire;
    logic                     hit_data;
    logic                     hit_status;
    logic [WB_DATA_WIDTH-1:0] rd_word;
    logic                     ack_r;
    logic [WB_DATA_WIDTH-1:0] dat_r;
    logic                     sw_flush_r;
    logic [WB_DATA_WIDTH-1:0] rename_cnt;
    logic [WB_DATA_WIDTH-1:0] retire_cnt;

    // A request is only taken while ack is low, so a held stb after the
    // ack cycle counts as a new request
    assign req    = i_wb.cyc && i_wb.stb && !ack_r;
    assign wr_req = req && i_wb.we;

    // Address decode
    assign word_aligned = (i_wb.adr[1:0] == 2'b00);
    assign hit_ctrl     = (i_wb.adr == CSR_CTRL);
    assign hit_rename   = (i_wb.adr == CSR_RENAME_CNT);
    assign hit_retire   = (i_wb.adr == CSR_RETIRE_CNT);
    assign hit_data     = word_aligned &&
        (i_wb.adr[WB_ADDR_WIDTH-1:WIN_LSB] == CSR_DATA_BASE[WB_ADDR_WIDTH-1:WIN_LSB]);
    assign hit_status   = word_aligned &&
        (i_wb.adr[WB_ADDR_WIDTH-1:WIN_LSB] == CSR_STATUS_BASE[WB_ADDR_WIDTH-1:WIN_LSB]);

    // The word index inside either window selects the register to read
    assign o_dbg_addr = i_wb.adr[WIN_LSB-1:2];

    // Read mux, unmapped offsets and CTRL read back as zero
    always_comb begin
        rd_word = '0;
        if (hit_rename) begin
            rd_word = rename_cnt;
        end else if (hit_retire) begin
            rd_word = retire_cnt;
        end else if (hit_data) begin
            rd_word = i_dbg.data;
        end else if (hit_status) begin
            // Ready flag in bit 8, producer tag in the low bits
            rd_word[8]             = i_dbg.rdy;
            rd_word[TAG_WIDTH-1:0] = i_dbg.tag;
        end
    end

    // Bus handshake and the flush command
    always_ff @(posedge clk) begin
        if (i_rst) begin
            ack_r      <= 1'b0;
            sw_flush_r <= 1'b0;
        end else begin
            ack_r      <= req;
            sw_flush_r <= wr_req && hit_ctrl && i_wb.dat[0];
        end
    end

    // Read data is captured with the request, writes return zero
    always_ff @(posedge clk) begin
        if (req) begin
            dat_r <= i_wb.we ? '0 : rd_word;
        end
    end

    // Event counters wrap, and any write to their offset clears them
    always_ff @(posedge clk) begin
        if (i_rst || (wr_req && hit_rename)) begin
            rename_cnt <= '0;
        end else if (i_rename_evt) begin
            rename_cnt <= rename_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst || (wr_req && hit_retire)) begin
            retire_cnt <= '0;
        end else if (i_retire_evt) begin
            retire_cnt <= retire_cnt + 1'b1;
        end
    end

    assign o_wb.ack   = ack_r;
    assign o_wb.dat   = dat_r;
    assign o_sw_flush = sw_flush_r;

    // Classic single-cycle ack never stretches across two clocks
    a_ack_single: assert property (@(posedge clk) disable iff (i_rst)
        o_wb.ack |=> !o_wb.ack);

endmodule

`default_nettype wire

//--- regmap_entry.sv
// ============================================================
// Single rename table entry
// Holds the last retired value, the newest producer tag and
// a ready bit, with flush over rename over retire priority
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module regmap_entry (
    input  logic                     clk,
    input  logic                     i_rst,

    // Branch or exception recovery, drops all in-flight producers
    input  logic                     i_flush,

    // New producer assigned by dispatch
    input  logic                     i_rename_en,
    input  regmap_pkg::regmap_tag_t  i_rename_tag,

    // Write-back from the ROB when an instruction retires
    input  logic                     i_retire_en,
    input  regmap_pkg::regmap_data_t i_retire_data,
    input  regmap_pkg::regmap_tag_t  i_retire_tag,

    output regmap_pkg::lookup_rsp_t  o_entry
);
    import regmap_pkg::*;

    regmap_data_t data_r;
    regmap_tag_t  tag_r;
    logic         rdy_r;
    logic         rdy_next;
    logic         tag_match;

    // A retire only completes the register if it comes from the newest producer
    assign tag_match = (i_retire_tag == tag_r);

    // Flushed producers will never write back, and the retired value is
    // already the correct architectural state, so a flush simply marks ready
    // A rename wins over a same-cycle retire because the newer producer
    // will overwrite the value anyway
    always_comb begin
        if (i_flush) begin
            rdy_next = 1'b1;
        end else if (i_rename_en) begin
            rdy_next = 1'b0;
        end else if (i_retire_en) begin
            rdy_next = rdy_r | tag_match;
        end else begin
            rdy_next = rdy_r;
        end
    end

    // Reset leaves the register ready with a zero value and tag
    always_ff @(posedge clk) begin
        if (i_rst) begin
            rdy_r  <= 1'b1;
            tag_r  <= '0;
            data_r <= '0;
        end else begin
            rdy_r <= rdy_next;
            if (i_rename_en) begin
                tag_r <= i_rename_tag;
            end
            // The value always tracks the latest retire, stale or not
            if (i_retire_en) begin
                data_r <= i_retire_data;
            end
        end
    end

    assign o_entry.data = data_r;
    assign o_entry.tag  = tag_r;
    assign o_entry.rdy  = rdy_r;

    // Any flush must leave the register ready on the following cycle
    a_flush_sets_rdy: assert property (@(posedge clk) disable iff (i_rst)
        i_flush |=> o_entry.rdy);

endmodule

`default_nettype wire

//--- regmap_pkg.sv
// ============================================================
// Shared definitions for the register map
// Widths, register count and Wishbone CSR offsets
// Scalar types for data, tags and register addresses
// Rename, retire, lookup and Wishbone request/response structs
// ============================================================
`default_nettype none

package regmap_pkg;

    // Core widths and the architectural register count
    localparam int DATA_WIDTH     = 32;
    localparam int TAG_WIDTH      = 5;
    localparam int REG_COUNT      = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // Wishbone bus geometry, byte addressed with a 32-bit data path
    localparam int WB_ADDR_WIDTH = 12;
    localparam int WB_DATA_WIDTH = 32;

    // CSR offsets; the two base offsets each open a window of REG_COUNT words
    localparam logic [WB_ADDR_WIDTH-1:0] CSR_CTRL        = 12'h000;
    localparam logic [WB_ADDR_WIDTH-1:0] CSR_RENAME_CNT  = 12'h004;
    localparam logic [WB_ADDR_WIDTH-1:0] CSR_RETIRE_CNT  = 12'h008;
    localparam logic [WB_ADDR_WIDTH-1:0] CSR_DATA_BASE   = 12'h100;
    localparam logic [WB_ADDR_WIDTH-1:0] CSR_STATUS_BASE = 12'h200;

    typedef logic [DATA_WIDTH-1:0]     regmap_data_t;
    typedef logic [TAG_WIDTH-1:0]      regmap_tag_t;
    typedef logic [REG_ADDR_WIDTH-1:0] regmap_addr_t;

    // Dispatch assigns a new ROB tag to a destination register
    typedef struct packed {
        logic         en;
        regmap_addr_t rd;
        regmap_tag_t  tag;
    } rename_req_t;

    // The ROB writes back a retired value along with its producer tag
    typedef struct packed {
        logic         en;
        regmap_addr_t rd;
        regmap_data_t data;
        regmap_tag_t  tag;
    } retire_req_t;

    // State of one register as seen by a lookup
    typedef struct packed {
        regmap_data_t data;
        regmap_tag_t  tag;
        logic         rdy;
    } lookup_rsp_t;

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [WB_ADDR_WIDTH-1:0] adr;
        logic [WB_DATA_WIDTH-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                     ack;
        logic [WB_DATA_WIDTH-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- regmap_top.sv
// ============================================================
// Register map top level
// Rename table array plus the Wishbone configuration block
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module regmap_top (
    input  logic                     clk,
    input  logic                     i_rst,

    // Branch or exception flush from the pipeline
    input  logic                     i_flush,

    input  regmap_pkg::rename_req_t  i_rename,
    input  regmap_pkg::retire_req_t  i_retire,

    input  regmap_pkg::regmap_addr_t i_src0_addr,
    input  regmap_pkg::regmap_addr_t i_src1_addr,
    output regmap_pkg::lookup_rsp_t  o_src0,
    output regmap_pkg::lookup_rsp_t  o_src1,

    // Configuration and debug bus
    input  regmap_pkg::wb_req_t      i_wb,
    output regmap_pkg::wb_rsp_t      o_wb
);
    import regmap_pkg::*;

    logic         sw_flush;
    logic         rename_evt;
    logic         retire_evt;
    regmap_addr_t dbg_addr;
    lookup_rsp_t  dbg_rsp;

    // Requests to register zero do not change state and are not counted
    assign rename_evt = i_rename.en && (i_rename.rd != '0);
    assign retire_evt = i_retire.en && (i_retire.rd != '0);

    regmap i_regmap (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_flush     (i_flush),
        .i_sw_flush  (sw_flush),
        .i_rename    (i_rename),
        .i_retire    (i_retire),
        .i_src0_addr (i_src0_addr),
        .i_src1_addr (i_src1_addr),
        .o_src0      (o_src0),
        .o_src1      (o_src1),
        .i_dbg_addr  (dbg_addr),
        .o_dbg       (dbg_rsp)
    );

    regmap_csr i_regmap_csr (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_wb         (i_wb),
        .o_wb         (o_wb),
        .i_rename_evt (rename_evt),
        .i_retire_evt (retire_evt),
        .o_sw_flush   (sw_flush),
        .o_dbg_addr   (dbg_addr),
        .i_dbg        (dbg_rsp)
    );

endmodule

`default_nettype wire

//--- tb.f
regmap_pkg.sv
regmap_entry.sv
regmap.sv
regmap_csr.sv
regmap_top.sv
tb_regmap.sv

//--- tb_regmap.sv
// ============================================================
// Directed testbench for the register map top level
// Reference model of data, tag and ready for each register
// Compare tasks, xorshift source and Wishbone master tasks
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module tb_regmap;
    import regmap_pkg::*;

    localparam int WB_TIMEOUT = 16;

    logic         clk;
    logic         i_rst;
    logic         i_flush;
    rename_req_t  i_rename;
    retire_req_t  i_retire;
    regmap_addr_t i_src0_addr;
    regmap_addr_t i_src1_addr;
    lookup_rsp_t  o_src0;
    lookup_rsp_t  o_src1;
    wb_req_t      i_wb;
    wb_rsp_t      o_wb;

    // Reference model of every register plus the expected event counts
    regmap_data_t             m_data [REG_COUNT];
    regmap_tag_t              m_tag  [REG_COUNT];
    logic                     m_rdy  [REG_COUNT];
    logic [WB_DATA_WIDTH-1:0] m_rename_cnt;
    logic [WB_DATA_WIDTH-1:0] m_retire_cnt;
    logic [31:0]              rng_state;
    int                       value_errors;
    int                       timeout_errors;

    regmap_top i_regmap_top (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_flush     (i_flush),
        .i_rename    (i_rename),
        .i_retire    (i_retire),
        .i_src0_addr (i_src0_addr),
        .i_src1_addr (i_src1_addr),
        .o_src0      (o_src0),
        .o_src1      (o_src1),
        .i_wb        (i_wb),
        .o_wb        (o_wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Any register except the hard-wired zero
    function automatic regmap_addr_t rand_reg();
        return regmap_addr_t'(1 + next_rand() % (REG_COUNT - 1));
    endfunction

    function automatic rename_req_t mk_rename(input regmap_addr_t rd, input regmap_tag_t tag);
        return '{en: 1'b1, rd: rd, tag: tag};
    endfunction

    function automatic retire_req_t mk_retire(input regmap_addr_t rd, input regmap_data_t data,
                                              input regmap_tag_t tag);
        return '{en: 1'b1, rd: rd, data: data, tag: tag};
    endfunction

    // Byte address of a register inside one of the readback windows
    function automatic logic [WB_ADDR_WIDTH-1:0] window_adr(input logic [WB_ADDR_WIDTH-1:0] base,
                                                            input regmap_addr_t r);
        return base + {5'b0, r, 2'b00};
    endfunction

    // Flush first, then rename, then a retire from the newest producer
    // The tag compare uses the tag held before this cycle's rename
    function automatic void model_apply(input rename_req_t rn, input retire_req_t rt,
                                        input logic fl);
        logic ren;
        logic ret;
        for (int r = 1; r < REG_COUNT; r++) begin
            ren = rn.en && (rn.rd == regmap_addr_t'(r));
            ret = rt.en && (rt.rd == regmap_addr_t'(r));
            if (fl) begin
                m_rdy[r] = 1'b1;
            end else if (ren) begin
                m_rdy[r] = 1'b0;
            end else if (ret && (rt.tag == m_tag[r])) begin
                m_rdy[r] = 1'b1;
            end
            if (ren) begin
                m_tag[r] = rn.tag;
            end
            if (ret) begin
                m_data[r] = rt.data;
            end
        end
        if (rn.en && (rn.rd != '0)) begin
            m_rename_cnt++;
        end
        if (rt.en && (rt.rd != '0)) begin
            m_retire_cnt++;
        end
    endfunction

    function automatic lookup_rsp_t model_rsp(input regmap_addr_t r);
        return '{data: m_data[r], tag: m_tag[r], rdy: m_rdy[r]};
    endfunction

    task automatic check_lookup(input string name, input lookup_rsp_t got, input lookup_rsp_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s = data %h tag %h rdy %b, expected data %h tag %h rdy %b",
                     $time, name, got.data, got.tag, got.rdy, exp.data, exp.tag, exp.rdy);
        end
    endtask

    task automatic check_wb_data(input string name, input regmap_data_t got,
                                 input regmap_data_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [WB_DATA_WIDTH-1:0] got,
                               input logic [WB_DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // Every task starts and ends 1 ns after a rising edge
    // One strobe cycle of rename, retire and flush, mirrored into the model
    task automatic issue(input rename_req_t rn, input retire_req_t rt, input logic fl);
        i_rename = rn;
        i_retire = rt;
        i_flush  = fl;
        model_apply(rn, rt, fl);
        @(posedge clk);
        #1;
        i_rename = '0;
        i_retire = '0;
        i_flush  = 1'b0;
    endtask

    // The second port looks at the mirrored register so both muxes are exercised
    task automatic check_reg(input regmap_addr_t r);
        regmap_addr_t m;
        m = ~r;
        i_src0_addr = r;
        i_src1_addr = m;
        @(negedge clk);
        check_lookup($sformatf("o_src0[x%0d]", r), o_src0, model_rsp(r));
        check_lookup($sformatf("o_src1[x%0d]", m), o_src1, model_rsp(m));
        @(posedge clk);
        #1;
    endtask

    task automatic check_all_regs();
        for (int r = 0; r < REG_COUNT / 2; r++) begin
            check_reg(regmap_addr_t'(r));
        end
    endtask

    // Holds the request until ack is seen and drops it after the ack cycle
    task automatic wb_access(input logic we, input logic [WB_ADDR_WIDTH-1:0] adr,
                             input logic [WB_DATA_WIDTH-1:0] wdat,
                             output logic [WB_DATA_WIDTH-1:0] rdat);
        int   waited;
        logic done;
        waited = 0;
        done   = 1'b0;
        rdat   = '0;
        i_wb   = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        while (!done && (waited < WB_TIMEOUT)) begin
            @(negedge clk);
            if (o_wb.ack) begin
                rdat = o_wb.dat;
                done = 1'b1;
            end else begin
                waited++;
            end
        end
        if (!done) begin
            timeout_errors++;
            $display("Wishbone access to %h got no ack within %0d cycles", adr, WB_TIMEOUT);
        end
        @(posedge clk);
        #1;
        i_wb = '0;
    endtask

    task automatic wb_read(input logic [WB_ADDR_WIDTH-1:0] adr,
                           output logic [WB_DATA_WIDTH-1:0] rdat);
        wb_access(1'b0, adr, '0, rdat);
    endtask

    task automatic wb_write(input logic [WB_ADDR_WIDTH-1:0] adr,
                            input logic [WB_DATA_WIDTH-1:0] wdat);
        logic [WB_DATA_WIDTH-1:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic check_counters();
        logic [WB_DATA_WIDTH-1:0] rdat;
        wb_read(CSR_RENAME_CNT, rdat);
        check_count("rename_cnt", rdat, m_rename_cnt);
        wb_read(CSR_RETIRE_CNT, rdat);
        check_count("retire_cnt", rdat, m_retire_cnt);
    endtask

    task automatic test_reset();
        for (int i = 0; i < 4; i++) begin
            check_reg(regmap_addr_t'(next_rand()));
        end
        check_counters();
    endtask

    task automatic test_rename_retire();
        regmap_addr_t r;
        regmap_tag_t  t;
        r = rand_reg();
        t = regmap_tag_t'(next_rand());
        issue(mk_rename(r, t), '0, 1'b0);
        check_reg(r);
        issue('0, mk_retire(r, next_rand(), t), 1'b0);
        check_reg(r);
        // A retire from an older producer updates the value only
        t = regmap_tag_t'(next_rand());
        issue(mk_rename(r, t), '0, 1'b0);
        issue('0, mk_retire(r, next_rand(), t ^ regmap_tag_t'(1)), 1'b0);
        check_reg(r);
    endtask

    // The retire carries the current producer tag and still loses to the rename
    task automatic test_collision();
        regmap_addr_t r;
        r = rand_reg();
        issue(mk_rename(r, regmap_tag_t'(next_rand())), mk_retire(r, next_rand(), m_tag[r]), 1'b0);
        check_reg(r);
    endtask

    task automatic test_flush();
        for (int i = 0; i < 4; i++) begin
            issue(mk_rename(rand_reg(), regmap_tag_t'(next_rand())),
                  mk_retire(rand_reg(), next_rand(), regmap_tag_t'(next_rand())), 1'b0);
        end
        issue('0, '0, 1'b1);
        check_all_regs();
        for (int i = 0; i < 3; i++) begin
            issue(mk_rename(rand_reg(), regmap_tag_t'(next_rand())), '0, 1'b0);
        end
        // The software flush lands on the edge that ends the ack cycle
        wb_write(CSR_CTRL, 32'h1);
        model_apply('0, '0, 1'b1);
        check_all_regs();
    endtask

    task automatic test_reg_zero();
        regmap_tag_t t;
        t = regmap_tag_t'(next_rand());
        issue(mk_rename('0, t), mk_retire('0, next_rand(), t), 1'b0);
        check_reg('0);
        check_counters();
    endtask

    task automatic test_readback();
        regmap_addr_t             r;
        logic [WB_DATA_WIDTH-1:0] rdat;
        // A fresh rename leaves the first register read back not ready
        r = rand_reg();
        issue(mk_rename(r, regmap_tag_t'(next_rand())), '0, 1'b0);
        for (int i = 0; i < 6; i++) begin
            wb_read(window_adr(CSR_DATA_BASE, r), rdat);
            check_wb_data($sformatf("data[x%0d]", r), rdat, m_data[r]);
            wb_read(window_adr(CSR_STATUS_BASE, r), rdat);
            check_wb_data($sformatf("status[x%0d]", r), rdat,
                          {23'b0, m_rdy[r], 3'b0, m_tag[r]});
            r = regmap_addr_t'(next_rand());
        end
        check_counters();
        wb_write(CSR_RENAME_CNT, next_rand());
        wb_write(CSR_RETIRE_CNT, next_rand());
        m_rename_cnt = '0;
        m_retire_cnt = '0;
        check_counters();
    endtask

    initial begin
        i_rst          = 1'b1;
        i_flush        = 1'b0;
        i_rename       = '0;
        i_retire       = '0;
        i_src0_addr    = '0;
        i_src1_addr    = '0;
        i_wb           = '0;
        rng_state      = 32'h9fe28353;
        value_errors   = 0;
        timeout_errors = 0;
        m_rename_cnt   = '0;
        m_retire_cnt   = '0;
        for (int r = 0; r < REG_COUNT; r++) begin
            m_data[r] = '0;
            m_tag[r]  = '0;
            m_rdy[r]  = 1'b1;
        end
        repeat (2) @(posedge clk);
        #1;
        i_rst = 1'b0;
        test_reset();
        test_rename_retire();
        test_collision();
        test_flush();
        test_reg_zero();
        test_readback();
        $display("Checks done: %0d value errors, %0d timeouts", value_errors, timeout_errors);
        if ((value_errors == 0) && (timeout_errors == 0)) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
